// ==== design/ntt_alu_pkg.sv ====
package ntt_alu_pkg;

  // polynomial size limit and coefficient width
  localparam int max_logn = 12;
  localparam int max_logq = 30;

  // memory returns read data one cycle after the read enable
  localparam int read_latency = 1;

  typedef logic [max_logq-1:0]   coeff_t;
  typedef logic [max_logq:0]     barrett_t;
  typedef logic [max_logn-1:0]   logn_t;
  typedef logic [max_logn-3:0]   word_addr_t;

  // {poly index, coefficient index mod 4}
  typedef logic [2:0]            bank_t;

  typedef enum logic [1:0] {
    op_nop  = 2'd0,
    op_conf = 2'd1,
    op_add  = 2'd2,
    op_mult = 2'd3
  } alu_op_e;

  typedef enum logic [1:0] {
    st_idle  = 2'd0,
    st_run   = 2'd1,
    st_drain = 2'd2
  } ctrl_state_e;

  // three multiplies plus two reduction stages
  function automatic int calc_arith_latency(input int mul_latency);
    return 3 * mul_latency + 2;
  endfunction

endpackage

// ==== design/alu_issue_if.sv ====
interface alu_issue_if;

  // one coefficient pair enters the arithmetic while valid is high
  logic                   valid;
  ntt_alu_pkg::alu_op_e   op;
  ntt_alu_pkg::coeff_t    q;
  ntt_alu_pkg::barrett_t  r;

  modport producer (
    output valid,
    output op,
    output q,
    output r
  );

  modport consumer (
    input valid,
    input op,
    input q,
    input r
  );

endinterface

// ==== design/poly_addr_gen.sv ====
module poly_addr_gen (
  input  logic                    clk,
  input  logic                    rst_n,

  input  ntt_alu_pkg::alu_op_e    op,
  input  ntt_alu_pkg::logn_t      cfg_logn,
  input  ntt_alu_pkg::coeff_t     cfg_q,
  input  ntt_alu_pkg::barrett_t   cfg_r,

  alu_issue_if.producer           issue,

  output ntt_alu_pkg::word_addr_t r_addr,
  output ntt_alu_pkg::bank_t      r_bank_0,
  output ntt_alu_pkg::bank_t      r_bank_1,
  output logic                    r_en,

  output logic                    wb_en,
  output ntt_alu_pkg::word_addr_t wb_addr,
  output ntt_alu_pkg::bank_t      wb_bank,
  input  logic                    busy,

  output logic                    done
);

  localparam int n_w = ntt_alu_pkg::max_logn + 1;

  ntt_alu_pkg::ctrl_state_e state;
  ntt_alu_pkg::alu_op_e     run_op;

  // configuration registers
  ntt_alu_pkg::logn_t       logn;
  ntt_alu_pkg::coeff_t      q;
  ntt_alu_pkg::barrett_t    r;

  // coefficient index and polynomial size
  ntt_alu_pkg::logn_t       k;
  logic [n_w-1:0]           n;
  logic                     last_k;

  assign n      = n_w'(1) << logn;
  assign last_k = ({1'b0, k} == (n - 1'b1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state  <= ntt_alu_pkg::st_idle;
      run_op <= ntt_alu_pkg::op_nop;
      logn   <= '0;
      q      <= '0;
      r      <= '0;
      k      <= '0;
    end else begin
      case (state)
        ntt_alu_pkg::st_idle: begin
          k <= '0;
          case (op)
            ntt_alu_pkg::op_conf: begin
              logn <= cfg_logn;
              q    <= cfg_q;
              r    <= cfg_r;
            end
            ntt_alu_pkg::op_add, ntt_alu_pkg::op_mult: begin
              run_op <= op;
              state  <= ntt_alu_pkg::st_run;
            end
            default: begin
            end
          endcase
        end
        ntt_alu_pkg::st_run: begin
          k <= k + 1'b1;
          if (last_k) begin
            state <= ntt_alu_pkg::st_drain;
          end
        end
        ntt_alu_pkg::st_drain: begin
          // wait for the last write to leave the output side
          if (!busy) begin
            state <= ntt_alu_pkg::st_idle;
          end
        end
        default: begin
          state <= ntt_alu_pkg::st_idle;
        end
      endcase
    end
  end

  // same index from both polynomials, result goes back to poly 1
  assign r_en     = (state == ntt_alu_pkg::st_run);
  assign r_addr   = k[ntt_alu_pkg::max_logn-1:2];
  assign r_bank_0 = {1'b0, k[1:0]};
  assign r_bank_1 = {1'b1, k[1:0]};

  assign wb_en    = r_en;
  assign wb_addr  = r_addr;
  assign wb_bank  = r_bank_1;

  assign done     = (state == ntt_alu_pkg::st_idle);

  // issue lines up with the data returned by the memory
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      issue.valid <= 1'b0;
    end else begin
      issue.valid <= r_en;
    end
  end

  always_ff @(posedge clk) begin
    issue.op <= run_op;
    issue.q  <= q;
    issue.r  <= r;
  end

endmodule

// ==== design/mod_arith_unit.sv ====
module mod_arith_unit #(
  parameter int mul_latency = 4
) (
  input  logic                 clk,
  input  logic                 rst_n,

  alu_issue_if.consumer        issue,

  input  ntt_alu_pkg::coeff_t  a,
  input  ntt_alu_pkg::coeff_t  b,
  output ntt_alu_pkg::coeff_t  result
);

  localparam int logq          = ntt_alu_pkg::max_logq;
  localparam int arith_latency = ntt_alu_pkg::calc_arith_latency(mul_latency);
  localparam int prod_w        = 2 * logq + 2;
  // the remainder before correction stays below 3q
  localparam int red_w         = logq + 2;

  // stage boundaries where new work starts
  localparam int mul2_at = mul_latency;
  localparam int mul3_at = 2 * mul_latency;
  localparam int sub0_at = 3 * mul_latency;
  localparam int sub1_at = 3 * mul_latency + 1;

  typedef struct packed {
    ntt_alu_pkg::alu_op_e op;
    logic [prod_w-1:0]    prod;
    logic [red_w-1:0]     xlo;
    ntt_alu_pkg::coeff_t  sum;
  } stage_t;

  stage_t                      entry;
  stage_t                      pipe [1:arith_latency];
  stage_t                      nxt  [1:arith_latency-1];
  logic [arith_latency-1:1]    vld;

  ntt_alu_pkg::coeff_t         q_hold;
  ntt_alu_pkg::barrett_t       r_hold;

  logic [2*logq-1:0]           x_full;
  logic [logq:0]               add_raw;
  logic [logq:0]               x_top;
  logic [logq:0]               est;
  logic [prod_w-1:0]           est_prod;
  logic [prod_w-1:0]           qest_prod;
  logic [red_w-1:0]            diff0;
  logic [red_w-1:0]            diff1;

  assign x_full  = a * b;
  assign add_raw = {1'b0, a} + {1'b0, b};

  always_comb begin
    entry.op   = issue.op;
    entry.prod = prod_w'(x_full);
    entry.xlo  = '0;
    // add path needs a single correction
    entry.sum  = (add_raw >= {1'b0, issue.q}) ? logq'(add_raw - issue.q) : logq'(add_raw);
  end

  // barrett quotient estimate from the top of x
  assign x_top     = pipe[mul2_at].prod[2*logq-1:logq-1];
  assign est_prod  = x_top * r_hold;
  assign est       = pipe[mul3_at].prod[2*logq+1:logq+1];
  assign qest_prod = est * q_hold;

  assign diff0 = pipe[sub0_at].xlo - pipe[sub0_at].prod[red_w-1:0];
  assign diff1 = pipe[sub1_at].prod[red_w-1:0];

  always_comb begin
    for (int i = 1; i < arith_latency; i++) begin
      nxt[i] = pipe[i];
    end
    nxt[mul2_at].xlo  = pipe[mul2_at].prod[red_w-1:0];
    nxt[mul2_at].prod = est_prod;
    nxt[mul3_at].prod = qest_prod;
    nxt[sub0_at].prod = prod_w'((diff0 >= q_hold) ? diff0 - q_hold : diff0);
    nxt[sub1_at].prod = prod_w'((diff1 >= q_hold) ? diff1 - q_hold : diff1);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld <= '0;
    end else begin
      vld <= {vld[arith_latency-2:1], issue.valid};
    end
  end

  // a stage only loads when its predecessor holds a coefficient
  always_ff @(posedge clk) begin
    if (issue.valid) begin
      pipe[1] <= entry;
      q_hold  <= issue.q;
      r_hold  <= issue.r;
    end
    for (int i = 1; i < arith_latency; i++) begin
      if (vld[i]) begin
        pipe[i+1] <= nxt[i];
      end
    end
  end

  assign result = (pipe[arith_latency].op == ntt_alu_pkg::op_mult)
                ? pipe[arith_latency].prod[logq-1:0]
                : pipe[arith_latency].sum;

endmodule

// ==== design/writeback_align.sv ====
module writeback_align #(
  parameter int mul_latency = 4
) (
  input  logic                    clk,
  input  logic                    rst_n,

  input  logic                    wb_en,
  input  ntt_alu_pkg::word_addr_t wb_addr,
  input  ntt_alu_pkg::bank_t      wb_bank,
  input  ntt_alu_pkg::coeff_t     result,

  output ntt_alu_pkg::word_addr_t w_addr,
  output ntt_alu_pkg::bank_t      w_bank,
  output logic                    w_en,
  output ntt_alu_pkg::coeff_t     w_data,
  output logic                    busy
);

  // memory read plus the arithmetic pipeline
  localparam int depth = ntt_alu_pkg::read_latency
                       + ntt_alu_pkg::calc_arith_latency(mul_latency);

  logic [depth-1:0]        en_pipe;
  ntt_alu_pkg::word_addr_t addr_pipe [depth];
  ntt_alu_pkg::bank_t      bank_pipe [depth];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      en_pipe <= '0;
    end else begin
      en_pipe <= {en_pipe[depth-2:0], wb_en};
    end
  end

  always_ff @(posedge clk) begin
    if (wb_en) begin
      addr_pipe[0] <= wb_addr;
      bank_pipe[0] <= wb_bank;
    end
    for (int i = 1; i < depth; i++) begin
      if (en_pipe[i-1]) begin
        addr_pipe[i] <= addr_pipe[i-1];
        bank_pipe[i] <= bank_pipe[i-1];
      end
    end
  end

  assign w_en   = en_pipe[depth-1];
  assign w_addr = addr_pipe[depth-1];
  assign w_bank = bank_pipe[depth-1];
  assign w_data = result;

  // any write still on its way to the memory
  assign busy   = |en_pipe;

endmodule

// ==== design/ntt_alu.sv ====
module ntt_alu #(
  parameter int mul_latency = 4
) (
  input  logic                    clk,
  input  logic                    rst_n,

  input  ntt_alu_pkg::alu_op_e    op,
  input  ntt_alu_pkg::logn_t      cfg_logn,
  input  ntt_alu_pkg::coeff_t     cfg_q,
  input  ntt_alu_pkg::barrett_t   cfg_r,

  output ntt_alu_pkg::word_addr_t r_addr_0,
  output ntt_alu_pkg::word_addr_t r_addr_1,
  output ntt_alu_pkg::bank_t      r_bank_0,
  output ntt_alu_pkg::bank_t      r_bank_1,
  output logic                    r_en_0,
  output logic                    r_en_1,
  input  ntt_alu_pkg::coeff_t     r_data_0,
  input  ntt_alu_pkg::coeff_t     r_data_1,

  output ntt_alu_pkg::word_addr_t w_addr_0,
  output ntt_alu_pkg::bank_t      w_bank_0,
  output logic                    w_en_0,
  output ntt_alu_pkg::coeff_t     w_data_0,

  output logic                    done
);

  ntt_alu_pkg::word_addr_t r_addr;
  logic                    r_en;
  logic                    wb_en;
  ntt_alu_pkg::word_addr_t wb_addr;
  ntt_alu_pkg::bank_t      wb_bank;
  logic                    busy;
  ntt_alu_pkg::coeff_t     result;

  alu_issue_if issue ();

  poly_addr_gen poly_addr_gen_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .op       (op),
    .cfg_logn (cfg_logn),
    .cfg_q    (cfg_q),
    .cfg_r    (cfg_r),
    .issue    (issue),
    .r_addr   (r_addr),
    .r_bank_0 (r_bank_0),
    .r_bank_1 (r_bank_1),
    .r_en     (r_en),
    .wb_en    (wb_en),
    .wb_addr  (wb_addr),
    .wb_bank  (wb_bank),
    .busy     (busy),
    .done     (done)
  );

  // both read ports fetch the same word address
  assign r_addr_0 = r_addr;
  assign r_addr_1 = r_addr;
  assign r_en_0   = r_en;
  assign r_en_1   = r_en;

  mod_arith_unit #(
    .mul_latency (mul_latency)
  ) mod_arith_unit_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .issue  (issue),
    .a      (r_data_0),
    .b      (r_data_1),
    .result (result)
  );

  writeback_align #(
    .mul_latency (mul_latency)
  ) writeback_align_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .wb_en   (wb_en),
    .wb_addr (wb_addr),
    .wb_bank (wb_bank),
    .result  (result),
    .w_addr  (w_addr_0),
    .w_bank  (w_bank_0),
    .w_en    (w_en_0),
    .w_data  (w_data_0),
    .busy    (busy)
  );

endmodule

// ==== bench/ntt_alu_assert.sv ====
module ntt_alu_assert (
  input logic clk,
  input logic rst_n,
  input logic r_en_0,
  input logic r_en_1,
  input logic w_en_0,
  input logic done
);

  timeunit 1ns;
  timeprecision 1ps;

  // both read ports fetch the same index
  read_ports_paired: assert property (
    @(posedge clk) disable iff (!rst_n) r_en_0 == r_en_1
  ) else $error("r_en_0 and r_en_1 differ");

  idle_no_access: assert property (
    @(posedge clk) disable iff (!rst_n) done |-> (!r_en_0 && !r_en_1 && !w_en_0)
  ) else $error("memory access while done is high");

  done_after_reset: assert property (
    @(posedge clk) $rose(rst_n) |-> done
  ) else $error("done low after reset");

endmodule

bind ntt_alu ntt_alu_assert ntt_alu_assert_inst (
  .clk    (clk),
  .rst_n  (rst_n),
  .r_en_0 (r_en_0),
  .r_en_1 (r_en_1),
  .w_en_0 (w_en_0),
  .done   (done)
);

// ==== bench/ntt_alu_tb.sv ====
module ntt_alu_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int words = 1 << (ntt_alu_pkg::max_logn - 2);
  localparam int max_n = 1 << ntt_alu_pkg::max_logn;
  // 20 * sum of (n + 20) over the runs: reset, 16, 16, 64, 32 and 32
  localparam int timeout_cycles = 20 * (20 + 36 + 36 + 84 + 52 + 52);

  logic                    clk = 1'b0;
  logic                    rst_n;
  ntt_alu_pkg::alu_op_e    op;
  ntt_alu_pkg::logn_t      cfg_logn;
  ntt_alu_pkg::coeff_t     cfg_q;
  ntt_alu_pkg::barrett_t   cfg_r;
  ntt_alu_pkg::word_addr_t r_addr_0;
  ntt_alu_pkg::word_addr_t r_addr_1;
  ntt_alu_pkg::bank_t      r_bank_0;
  ntt_alu_pkg::bank_t      r_bank_1;
  logic                    r_en_0;
  logic                    r_en_1;
  ntt_alu_pkg::coeff_t     r_data_0 = '0;
  ntt_alu_pkg::coeff_t     r_data_1 = '0;
  ntt_alu_pkg::word_addr_t w_addr_0;
  ntt_alu_pkg::bank_t      w_bank_0;
  logic                    w_en_0;
  ntt_alu_pkg::coeff_t     w_data_0;
  logic                    done;

  // bank index is {poly, k mod 4}, word address is k / 4
  ntt_alu_pkg::coeff_t     mem [8][words];
  ntt_alu_pkg::coeff_t     ref_a [max_n];
  ntt_alu_pkg::coeff_t     ref_b [max_n];
  integer                  seed;
  int                      errors = 0;
  int                      tests = 0;
  int                      write_count = 0;
  int                      cycle_count = 0;

  ntt_alu #(.mul_latency (4)) ntt_alu_inst (.*);

  always #5 clk = ~clk;

  // memory with one cycle of read latency
  always @(posedge clk) begin
    ntt_alu_pkg::coeff_t d0;
    ntt_alu_pkg::coeff_t d1;
    d0 = r_data_0;
    d1 = r_data_1;
    if (w_en_0) begin
      mem[w_bank_0][w_addr_0] = w_data_0;
      write_count = write_count + 1;
    end
    if (r_en_0) begin
      d0 = mem[r_bank_0][r_addr_0];
      d1 = mem[r_bank_1][r_addr_1];
    end
    #1;
    r_data_0 = d0;
    r_data_1 = d1;
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > timeout_cycles) begin
      $display("timeout: the run did not end within %0d cycles", timeout_cycles);
      $display("Some tests failed");
      $finish;
    end
  end

  task automatic check_coeff(input string name, input ntt_alu_pkg::coeff_t got,
                             input ntt_alu_pkg::coeff_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  function automatic ntt_alu_pkg::coeff_t rand_below(input ntt_alu_pkg::coeff_t q);
    logic [31:0] v;
    v = $random(seed);
    return ntt_alu_pkg::coeff_t'(v % {2'b00, q});
  endfunction

  task automatic set_pair(input int k, input ntt_alu_pkg::coeff_t a,
                          input ntt_alu_pkg::coeff_t b);
    ref_a[k] = a;
    ref_b[k] = b;
    mem[k % 4][k / 4] = a;
    mem[4 + k % 4][k / 4] = b;
  endtask

  task automatic start_op(input ntt_alu_pkg::alu_op_e o, input logic done_exp);
    op = o;
    @(posedge clk);
    #1;
    op = ntt_alu_pkg::op_nop;
    check_flag("done", done, done_exp);
  endtask

  task automatic configure(input int logn, input ntt_alu_pkg::coeff_t q);
    logic [63:0] r_full;
    // r = floor(2^60 / q)
    r_full   = (64'd1 << 60) / 64'(q);
    cfg_logn = ntt_alu_pkg::logn_t'(logn);
    cfg_q    = q;
    cfg_r    = ntt_alu_pkg::barrett_t'(r_full);
    start_op(ntt_alu_pkg::op_conf, 1'b1);
  endtask

  task automatic wait_done();
    while (done !== 1'b1) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic check_poly(input int n, input ntt_alu_pkg::coeff_t q, input logic mult);
    logic [63:0] want;
    for (int k = 0; k < n; k++) begin
      if (mult) begin
        want = (64'(ref_a[k]) * 64'(ref_b[k])) % 64'(q);
      end else begin
        want = (64'(ref_a[k]) + 64'(ref_b[k])) % 64'(q);
      end
      check_coeff($sformatf("poly0[%0d]", k), mem[k % 4][k / 4], ref_a[k]);
      check_coeff($sformatf("poly1[%0d]", k), mem[4 + k % 4][k / 4],
                  ntt_alu_pkg::coeff_t'(want));
      ref_b[k] = ntt_alu_pkg::coeff_t'(want);
    end
  endtask

  task automatic run_op_check(input ntt_alu_pkg::alu_op_e o, input int n,
                              input ntt_alu_pkg::coeff_t q, input logic poke);
    int writes_before;
    writes_before = write_count;
    start_op(o, 1'b0);
    if (poke) begin
      // an op while the unit runs has to be ignored
      repeat (5) @(posedge clk);
      #1;
      op = ntt_alu_pkg::op_add;
      @(posedge clk);
      #1;
      op = ntt_alu_pkg::op_nop;
      check_flag("done", done, 1'b0);
    end
    wait_done();
    if (write_count - writes_before != n) begin
      $display("wrong number of writes: %0d where %0d were due",
               write_count - writes_before, n);
      errors++;
    end
    check_poly(n, q, o == ntt_alu_pkg::op_mult);
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests++;
    $display("test %-16s %s, %0d errors", name,
             (errors == errors_before) ? "ok" : "failed", errors - errors_before);
  endtask

  task automatic test_reset_state();
    int errors_before;
    errors_before = errors;
    check_flag("done", done, 1'b1);
    check_flag("r_en_0", r_en_0, 1'b0);
    check_flag("r_en_1", r_en_1, 1'b0);
    check_flag("w_en_0", w_en_0, 1'b0);
    finish_test("reset_state", errors_before);
  endtask

  task automatic run_test(input string name, input ntt_alu_pkg::alu_op_e o, input int logn,
                          input ntt_alu_pkg::coeff_t q, input logic extremes, input logic poke);
    int errors_before;
    int n;
    errors_before = errors;
    n = 1 << logn;
    configure(logn, q);
    for (int k = 0; k < n; k++) begin
      set_pair(k, rand_below(q), rand_below(q));
    end
    if (extremes) begin
      set_pair(0, q - 1'b1, q - 1'b1);
      set_pair(1, '0, q - 1'b1);
      set_pair(2, q - 1'b1, '0);
      set_pair(3, q - 1'b1, 30'd1);
    end
    run_op_check(o, n, q, poke);
    if (poke) begin
      // second op works on the results of the first
      run_op_check(ntt_alu_pkg::op_add, n, q, 1'b0);
    end
    finish_test(name, errors_before);
  endtask

  initial begin
    seed     = 32'h6f8e_463d;
    rst_n    = 1'b0;
    op       = ntt_alu_pkg::op_nop;
    cfg_logn = '0;
    cfg_q    = '0;
    cfg_r    = '0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    test_reset_state();
    run_test("add_n16", ntt_alu_pkg::op_add, 4, 30'd12289, 1'b0, 1'b0);
    // barrett reduction needs a modulus that fills the coefficient width
    run_test("mult_n16", ntt_alu_pkg::op_mult, 4, 30'd998244353, 1'b0, 1'b0);
    run_test("mult_extremes", ntt_alu_pkg::op_mult, 6, 30'd1073479681, 1'b1, 1'b0);
    // the running multiply must not turn into the add applied meanwhile
    run_test("add_while_busy", ntt_alu_pkg::op_mult, 5, 30'd1073479681, 1'b0, 1'b1);
    $display("tests %0d, writes %0d, errors %0d", tests, write_count, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== build.f ====
design/ntt_alu_pkg.sv
design/alu_issue_if.sv
design/poly_addr_gen.sv
design/mod_arith_unit.sv
design/writeback_align.sv
design/ntt_alu.sv
bench/ntt_alu_assert.sv
bench/ntt_alu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the ntt_alu testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module ntt_alu_tb \
  -f build.f -Mdir obj_dir -o ntt_alu_sim \
  && ./obj_dir/ntt_alu_sim > sim.log 2>&1 \
  || echo "Some tests failed" >> sim.log

if grep -q "Some tests failed" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
echo "simulation passed"
